// ==== hw/snn_tile_pkg.sv ====
package snn_tile_pkg;

    // ========================================
    // Default tile sizes
    // ========================================
    localparam int DEF_ROWS      = 8;  // TCAM rows per timestep
    localparam int DEF_SPIKES    = 8;  // Spike pattern width
    localparam int DEF_TIMESTEPS = 4;  // Buffer depth in timesteps

    // ========================================
    // FSM state encodings
    // ========================================
    typedef enum logic [1:0] {
        INJ_IDLE = 2'd0,  // Waiting for tile_start
        INJ_LOAD = 2'd1,  // Streaming rows into the TCAM
        INJ_DONE = 2'd2   // One cycle to flag completion
    } inject_state_t;

    typedef enum logic [1:0] {
        CTRL_IDLE   = 2'd0,
        CTRL_INJECT = 2'd1,  // Injector busy with current timestep
        CTRL_DETECT = 2'd2,  // Detector walking the rows
        CTRL_NEXT   = 2'd3   // Advance or finish
    } ctrl_state_t;

    typedef enum logic [1:0] {
        DET_IDLE  = 2'd0,
        DET_ISSUE = 2'd1,  // One search per cycle
        DET_DRAIN = 2'd2   // Waiting for the last record
    } detect_state_t;

endpackage

// ==== hw/timestep_controller.sv ====
module timestep_controller import snn_tile_pkg::*; #(
    parameter int MAX_TIMESTEPS = DEF_TIMESTEPS
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               run,           // Start pulse, ignored while busy
    input  logic [$clog2(MAX_TIMESTEPS+1)-1:0] num_timesteps, // Sampled with run
    input  logic                               inject_done,
    input  logic                               detect_done,
    output logic                               tile_start,
    output logic [$clog2(MAX_TIMESTEPS)-1:0]   timestep_idx,  // Held for the whole timestep
    output logic                               detect_start,
    output logic                               busy,
    output logic                               run_done
);

    localparam int TS_W  = $clog2(MAX_TIMESTEPS);
    localparam int CNT_W = $clog2(MAX_TIMESTEPS + 1);

    ctrl_state_t      state;
    logic [CNT_W-1:0] ts_count;  // Latched run length
    logic [CNT_W-1:0] ts_next;   // Current index plus one, count width

    assign ts_next = CNT_W'(timestep_idx) + CNT_W'(1);
    assign busy    = (state != CTRL_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= CTRL_IDLE;
            ts_count     <= '0;
            timestep_idx <= '0;
            tile_start   <= 1'b0;
            detect_start <= 1'b0;
            run_done     <= 1'b0;
        end else begin
            tile_start   <= 1'b0;  // Pulses by default
            detect_start <= 1'b0;
            run_done     <= 1'b0;
            case (state)
                CTRL_IDLE: begin
                    // Zero-length run is dropped
                    if (run && num_timesteps != '0) begin
                        ts_count     <= num_timesteps;
                        timestep_idx <= '0;
                        tile_start   <= 1'b1;
                        state        <= CTRL_INJECT;
                    end
                end
                CTRL_INJECT: begin
                    if (inject_done) begin
                        detect_start <= 1'b1;  // TCAM now holds this timestep
                        state        <= CTRL_DETECT;
                    end
                end
                CTRL_DETECT: begin
                    if (detect_done)
                        state <= CTRL_NEXT;
                end
                CTRL_NEXT: begin
                    if (ts_next == ts_count) begin  // Last timestep finished
                        run_done <= 1'b1;
                        state    <= CTRL_IDLE;
                    end else begin
                        timestep_idx <= TS_W'(ts_next);
                        tile_start   <= 1'b1;
                        state        <= CTRL_INJECT;
                    end
                end
                default: state <= CTRL_IDLE;
            endcase
        end
    end

endmodule

// ==== hw/spike_injector.sv ====
module spike_injector import snn_tile_pkg::*; #(
    parameter int ROWS          = DEF_ROWS,
    parameter int SPIKES        = DEF_SPIKES,
    parameter int MAX_TIMESTEPS = DEF_TIMESTEPS
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    // Controller side
    input  logic                                    tile_start,
    input  logic [$clog2(MAX_TIMESTEPS)-1:0]        timestep_idx,
    output logic                                    inject_done,
    // Host buffer writes
    input  logic                                    host_wr_en,
    input  logic [$clog2(MAX_TIMESTEPS*ROWS)-1:0]   host_wr_addr,  // timestep*ROWS + row
    input  logic [SPIKES-1:0]                       host_wr_data,
    // TCAM set port
    output logic                                    tcam_set_en,
    output logic [$clog2(ROWS)-1:0]                 tcam_set_addr,
    output logic [SPIKES-1:0]                       tcam_set_key
);

    localparam int RW   = $clog2(ROWS);
    localparam int TS_W = $clog2(MAX_TIMESTEPS);
    localparam int HA_W = $clog2(MAX_TIMESTEPS * ROWS);

    // ========================================
    // Spike buffer
    // ========================================
    logic [SPIKES-1:0] spike_buf [MAX_TIMESTEPS*ROWS];

    always_ff @(posedge clk) begin
        if (host_wr_en)
            spike_buf[host_wr_addr] <= host_wr_data;
    end

    // ========================================
    // Load sequencing
    // ========================================
    inject_state_t   state;
    inject_state_t   next_state;
    logic [RW-1:0]   row_cnt;
    logic [TS_W-1:0] ts_latched;  // Captured on tile_start
    logic [HA_W-1:0] base_addr;
    logic [HA_W-1:0] rd_addr;

    assign base_addr = HA_W'(ts_latched) * HA_W'(ROWS);
    assign rd_addr   = base_addr + HA_W'(row_cnt);

    always_comb begin
        next_state = state;
        case (state)
            INJ_IDLE: if (tile_start) next_state = INJ_LOAD;
            INJ_LOAD: if (row_cnt == RW'(ROWS - 1)) next_state = INJ_DONE;
            INJ_DONE: next_state = INJ_IDLE;
            default:  next_state = INJ_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            state <= INJ_IDLE;
        else
            state <= next_state;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_cnt     <= '0;
            ts_latched  <= '0;
            tcam_set_en <= 1'b0;
            inject_done <= 1'b0;
        end else begin
            tcam_set_en <= 1'b0;
            inject_done <= 1'b0;
            case (state)
                INJ_IDLE: begin
                    if (tile_start) begin
                        row_cnt    <= '0;
                        ts_latched <= timestep_idx;
                    end
                end
                INJ_LOAD: begin
                    tcam_set_en <= 1'b1;  // One row per cycle, ascending
                    if (row_cnt != RW'(ROWS - 1))
                        row_cnt <= row_cnt + 1'b1;
                end
                INJ_DONE: inject_done <= 1'b1;
                default: ;
            endcase
        end
    end

    // Set payload, qualified by tcam_set_en
    always_ff @(posedge clk) begin
        tcam_set_addr <= row_cnt;
        tcam_set_key  <= spike_buf[rd_addr];
    end

endmodule

// ==== hw/subset_tcam.sv ====
module subset_tcam #(
    parameter int ROWS   = 8,
    parameter int SPIKES = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    // Row write port
    input  logic                    set_en,
    input  logic [$clog2(ROWS)-1:0] set_addr,
    input  logic [SPIKES-1:0]       set_key,
    // Search port
    input  logic                    search_en,
    input  logic [$clog2(ROWS)-1:0] search_row,  // Query is this row's own key
    output logic                    hit_valid,
    output logic                    hit,
    output logic [$clog2(ROWS)-1:0] hit_row,
    output logic [SPIKES-1:0]       query_key,
    output logic [SPIKES-1:0]       hit_key
);

    localparam int RW = $clog2(ROWS);

    // ========================================
    // Key storage
    // ========================================
    logic [SPIKES-1:0] keys [ROWS];

    always_ff @(posedge clk) begin
        if (set_en)
            keys[set_addr] <= set_key;
    end

    // ========================================
    // Parallel subset compare
    // ========================================
    logic [SPIKES-1:0] query;
    logic [ROWS-1:0]   match;   // One flag per candidate row
    logic              found;
    logic [RW-1:0]     sel_row;

    always_comb begin
        query = keys[search_row];
        for (int j = 0; j < ROWS; j++) begin
            match[j] = (RW'(j) < search_row)        // Earlier rows only
                    && (keys[j] != '0)              // Empty row never a prefix
                    && ((keys[j] & ~query) == '0);  // No bit outside the query
        end
    end

    // Lowest index wins
    always_comb begin
        found   = 1'b0;
        sel_row = '0;
        for (int j = 0; j < ROWS; j++) begin
            if (match[j] && !found) begin
                found   = 1'b1;
                sel_row = RW'(j);
            end
        end
    end

    // ========================================
    // Registered result
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n)
            hit_valid <= 1'b0;
        else
            hit_valid <= search_en;
    end

    always_ff @(posedge clk) begin
        if (search_en) begin
            hit       <= found;
            hit_row   <= sel_row;  // Zero on a miss
            query_key <= query;
            hit_key   <= found ? keys[sel_row] : '0;
        end
    end

endmodule

// ==== hw/sparsity_detector.sv ====
module sparsity_detector import snn_tile_pkg::*; #(
    parameter int ROWS   = DEF_ROWS,
    parameter int SPIKES = DEF_SPIKES
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    detect_start,
    // TCAM result
    input  logic                    hit_valid,
    input  logic                    hit,
    input  logic [$clog2(ROWS)-1:0] hit_row,
    input  logic [SPIKES-1:0]       query_key,
    input  logic [SPIKES-1:0]       hit_key,
    // TCAM search
    output logic                    search_en,
    output logic [$clog2(ROWS)-1:0] search_row,
    output logic                    detect_done,
    // Output record
    output logic                    out_valid,
    output logic [$clog2(ROWS)-1:0] out_row,
    output logic                    out_hit,
    output logic [$clog2(ROWS)-1:0] out_prefix_row,
    output logic [SPIKES-1:0]       out_residual
);

    localparam int RW = $clog2(ROWS);

    detect_state_t state;
    logic [RW-1:0] tag_row;   // Row of the search now in the TCAM stage
    logic          tag_last;  // That search was the final row
    logic          out_last;  // Current record is the final row

    // ========================================
    // Search issue
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= DET_IDLE;
            search_en   <= 1'b0;
            search_row  <= '0;
            detect_done <= 1'b0;
        end else begin
            detect_done <= 1'b0;
            case (state)
                DET_IDLE: if (detect_start) begin
                    search_en  <= 1'b1;
                    search_row <= '0;
                    state      <= DET_ISSUE;
                end
                DET_ISSUE: begin
                    if (search_row == RW'(ROWS - 1)) begin
                        search_en <= 1'b0;
                        state     <= DET_DRAIN;
                    end else begin
                        search_row <= search_row + 1'b1;
                    end
                end
                DET_DRAIN: if (out_valid && out_last) begin
                    detect_done <= 1'b1;  // Cycle after the last record
                    state       <= DET_IDLE;
                end
                default: state <= DET_IDLE;
            endcase
        end
    end

    // ========================================
    // Row tag pipeline and records
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tag_last  <= 1'b0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            tag_last  <= search_en && (search_row == RW'(ROWS - 1));
            out_valid <= hit_valid;
            out_last  <= hit_valid && tag_last;
        end
    end

    always_ff @(posedge clk) begin
        if (search_en)
            tag_row <= search_row;  // Matches TCAM latency
        if (hit_valid) begin
            out_row        <= tag_row;
            out_hit        <= hit;
            out_prefix_row <= hit ? hit_row : '0;
            out_residual   <= hit ? (query_key & ~hit_key) : query_key;  // Strip the prefix
        end
    end

endmodule

// ==== hw/prosperity_tile.sv ====
module prosperity_tile import snn_tile_pkg::*; #(
    parameter int ROWS          = DEF_ROWS,
    parameter int SPIKES        = DEF_SPIKES,
    parameter int MAX_TIMESTEPS = DEF_TIMESTEPS
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  run,
    input  logic [$clog2(MAX_TIMESTEPS+1)-1:0]    num_timesteps,
    input  logic                                  host_wr_en,
    input  logic [$clog2(MAX_TIMESTEPS*ROWS)-1:0] host_wr_addr,
    input  logic [SPIKES-1:0]                     host_wr_data,
    output logic                                  busy,
    output logic                                  run_done,
    output logic                                  out_valid,
    output logic [$clog2(MAX_TIMESTEPS)-1:0]      out_timestep,
    output logic [$clog2(ROWS)-1:0]               out_row,
    output logic                                  out_hit,
    output logic [$clog2(ROWS)-1:0]               out_prefix_row,
    output logic [SPIKES-1:0]                     out_residual
);

    localparam int RW   = $clog2(ROWS);
    localparam int TS_W = $clog2(MAX_TIMESTEPS);

    // Controller links
    logic            tile_start;
    logic            inject_done;
    logic            detect_start;
    logic            detect_done;
    logic [TS_W-1:0] timestep_idx;

    // TCAM ports
    logic              tcam_set_en;
    logic [RW-1:0]     tcam_set_addr;
    logic [SPIKES-1:0] tcam_set_key;
    logic              search_en;
    logic [RW-1:0]     search_row;
    logic              hit_valid;
    logic              hit;
    logic [RW-1:0]     hit_row;
    logic [SPIKES-1:0] query_key;
    logic [SPIKES-1:0] hit_key;

    assign out_timestep = timestep_idx;  // Held through detection

    timestep_controller #(
        .MAX_TIMESTEPS(MAX_TIMESTEPS)
    ) u_ctrl (
        .clk(clk), .rst_n(rst_n), .run(run), .num_timesteps(num_timesteps),
        .inject_done(inject_done), .detect_done(detect_done),
        .tile_start(tile_start), .timestep_idx(timestep_idx),
        .detect_start(detect_start), .busy(busy), .run_done(run_done)
    );

    spike_injector #(
        .ROWS(ROWS), .SPIKES(SPIKES), .MAX_TIMESTEPS(MAX_TIMESTEPS)
    ) u_inject (
        .clk(clk), .rst_n(rst_n), .tile_start(tile_start), .timestep_idx(timestep_idx),
        .inject_done(inject_done), .host_wr_en(host_wr_en),
        .host_wr_addr(host_wr_addr), .host_wr_data(host_wr_data),
        .tcam_set_en(tcam_set_en), .tcam_set_addr(tcam_set_addr),
        .tcam_set_key(tcam_set_key)
    );

    subset_tcam #(
        .ROWS(ROWS), .SPIKES(SPIKES)
    ) u_tcam (
        .clk(clk), .rst_n(rst_n), .set_en(tcam_set_en), .set_addr(tcam_set_addr),
        .set_key(tcam_set_key), .search_en(search_en), .search_row(search_row),
        .hit_valid(hit_valid), .hit(hit), .hit_row(hit_row),
        .query_key(query_key), .hit_key(hit_key)
    );

    sparsity_detector #(
        .ROWS(ROWS), .SPIKES(SPIKES)
    ) u_detect (
        .clk(clk), .rst_n(rst_n), .detect_start(detect_start),
        .hit_valid(hit_valid), .hit(hit), .hit_row(hit_row),
        .query_key(query_key), .hit_key(hit_key),
        .search_en(search_en), .search_row(search_row), .detect_done(detect_done),
        .out_valid(out_valid), .out_row(out_row), .out_hit(out_hit),
        .out_prefix_row(out_prefix_row), .out_residual(out_residual)
    );

endmodule

// ==== testbench/prosperity_tile_props.sv ====
module prosperity_tile_props #(
    parameter int ROWS = 8
) (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    busy,
    input logic                    run_done,
    input logic                    out_valid,
    input logic                    out_hit,
    input logic [$clog2(ROWS)-1:0] out_row,
    input logic [$clog2(ROWS)-1:0] out_prefix_row
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RW = $clog2(ROWS);

    int fail_count = 0;  // Failed assertions so far

    // ========================================
    // Control protocol
    // ========================================
    a_valid_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> busy)
        else begin
            $error("out_valid outside a run");
            fail_count++;
        end

    a_done_ends_busy: assert property (@(posedge clk) disable iff (!rst_n)
        run_done |-> (!busy && $past(busy)))
        else begin
            $error("run_done did not end busy");
            fail_count++;
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        run_done |=> !run_done)  // Single cycle only
        else begin
            $error("run_done longer than one cycle");
            fail_count++;
        end

    a_prefix_earlier: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && out_hit) |-> (out_prefix_row < out_row))
        else begin
            $error("prefix row not earlier than its row");
            fail_count++;
        end

    // Records of one timestep come back to back
    a_row_step: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && $past(out_valid)) |-> (out_row == RW'($past(out_row) + 1'b1)))
        else begin
            $error("out_row skipped within a timestep");
            fail_count++;
        end

endmodule

// ==== testbench/tb_prosperity_tile.sv ====
module tb_prosperity_tile import snn_tile_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ROWS          = DEF_ROWS;
    localparam int SPIKES        = DEF_SPIKES;
    localparam int MAX_TIMESTEPS = DEF_TIMESTEPS;
    localparam int RW    = $clog2(ROWS);
    localparam int TS_W  = $clog2(MAX_TIMESTEPS);
    localparam int CNT_W = $clog2(MAX_TIMESTEPS + 1);
    localparam int HA_W  = $clog2(MAX_TIMESTEPS * ROWS);

    // Idle, handcrafted, multi, zero/identical, random, two back-to-back runs
    localparam int RUN_TIMESTEPS   = 1 + 1 + MAX_TIMESTEPS + 2 + 2 * MAX_TIMESTEPS + 2;
    localparam int WATCHDOG_CYCLES = RUN_TIMESTEPS * (2 * ROWS + 10) * 4;

    // Zero row, duplicates, supersets and lowest index wins
    localparam logic [7:0] HAND [8] = '{8'h00, 8'h03, 8'h03, 8'h07,
                                        8'h01, 8'h0F, 8'h10, 8'h11};

    logic              clk;
    logic              rst_n;
    logic              run;
    logic [CNT_W-1:0]  num_timesteps;
    logic              host_wr_en;
    logic [HA_W-1:0]   host_wr_addr;
    logic [SPIKES-1:0] host_wr_data;
    logic              busy;
    logic              run_done;
    logic              out_valid;
    logic [TS_W-1:0]   out_timestep;
    logic [RW-1:0]     out_row;
    logic              out_hit;
    logic [RW-1:0]     out_prefix_row;
    logic [SPIKES-1:0] out_residual;

    logic [SPIKES-1:0] model_buf [MAX_TIMESTEPS*ROWS];  // Mirror of host writes
    logic [15:0]       lfsr;
    int                errors;
    int                tests_run;
    int                tests_failed;

    prosperity_tile #(
        .ROWS(ROWS), .SPIKES(SPIKES), .MAX_TIMESTEPS(MAX_TIMESTEPS)
    ) UUT (
        .clk(clk), .rst_n(rst_n), .run(run), .num_timesteps(num_timesteps),
        .host_wr_en(host_wr_en), .host_wr_addr(host_wr_addr), .host_wr_data(host_wr_data),
        .busy(busy), .run_done(run_done), .out_valid(out_valid),
        .out_timestep(out_timestep), .out_row(out_row), .out_hit(out_hit),
        .out_prefix_row(out_prefix_row), .out_residual(out_residual)
    );

    bind prosperity_tile prosperity_tile_props #(.ROWS(ROWS)) u_props (
        .clk(clk), .rst_n(rst_n), .busy(busy), .run_done(run_done),
        .out_valid(out_valid), .out_hit(out_hit), .out_row(out_row),
        .out_prefix_row(out_prefix_row)
    );

    always #4 clk = ~clk;  // 8 ns period

    // ========================================
    // Stimulus and reference model
    // ========================================
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // Galois form with taps 16 14 13 11
    endfunction

    task automatic draw_pattern(output logic [SPIKES-1:0] p);
        logic [SPIKES-1:0] a;
        logic [SPIKES-1:0] b;
        for (int i = 0; i < 2 * SPIKES; i++) begin
            if (i < SPIKES)
                a[i] = lfsr[0];
            else
                b[i - SPIKES] = lfsr[0];
            lfsr = lfsr_next(lfsr);  // One step per bit
        end
        p = a & b;  // Sparse spikes give more subsets
    endtask

    task automatic write_entry(input int ts, input int row, input logic [SPIKES-1:0] data);
        @(posedge clk);
        host_wr_en   <= 1'b1;
        host_wr_addr <= HA_W'(ts * ROWS + row);
        host_wr_data <= data;
        model_buf[ts * ROWS + row] = data;
    endtask

    task automatic end_writes();
        @(posedge clk);
        host_wr_en <= 1'b0;
    endtask

    // Lowest earlier nonzero subset row is the prefix
    function automatic void expect_row(input int ts, input int row, output logic exp_hit,
                                       output int exp_pre, output logic [SPIKES-1:0] exp_res);
        logic [SPIKES-1:0] q;
        logic [SPIKES-1:0] k;
        q       = model_buf[ts * ROWS + row];
        exp_hit = 1'b0;
        exp_pre = 0;
        exp_res = q;
        for (int j = 0; j < row; j++) begin
            k = model_buf[ts * ROWS + j];
            if (!exp_hit && k != '0 && (k & ~q) == '0) begin
                exp_hit = 1'b1;
                exp_pre = j;
                exp_res = q & ~k;
            end
        end
    endfunction

    // ========================================
    // Checking helpers
    // ========================================
    task automatic report_error(input string msg);
        $display("ERROR: %s", msg);
        errors++;
    endtask

    task automatic compare_field(input string test, input string field, input int rec,
                                 input logic [31:0] exp_val, input logic [31:0] act_val);
        if (act_val !== exp_val) begin
            $display("mismatch %s record %0d %s: expected %0h actual %0h",
                     test, rec, field, exp_val, act_val);
            errors++;
        end
    endtask

    task automatic finish_test(input string test, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("%s: ok", test);
        end else begin
            tests_failed++;
            $display("%s: FAILED, %0d errors", test, errors - errs_before);
        end
    endtask

    // Pulse run, collect records until run_done, compare each with the model
    task automatic run_and_check(input string test, input int nts);
        int                rec;
        logic              exp_hit;
        int                exp_pre;
        logic [SPIKES-1:0] exp_res;
        bit                finished;
        rec      = 0;
        finished = 0;
        @(posedge clk);
        run           <= 1'b1;
        num_timesteps <= CNT_W'(nts);
        @(posedge clk);
        run <= 1'b0;
        @(negedge clk);
        if (!busy)
            report_error($sformatf("%s: busy did not rise after run", test));
        while (!finished) begin
            @(negedge clk);
            if (out_valid && rec >= nts * ROWS) begin
                report_error($sformatf("%s: extra record beyond %0d", test, nts * ROWS));
                rec++;
            end else if (out_valid) begin
                expect_row(rec / ROWS, rec % ROWS, exp_hit, exp_pre, exp_res);
                compare_field(test, "timestep", rec, rec / ROWS, out_timestep);
                compare_field(test, "row", rec, rec % ROWS, out_row);
                compare_field(test, "hit", rec, exp_hit, out_hit);
                compare_field(test, "prefix_row", rec, exp_pre, out_prefix_row);
                compare_field(test, "residual", rec, exp_res, out_residual);
                rec++;
            end
            if (run_done)
                finished = 1;
        end
        compare_field(test, "record count", rec, nts * ROWS, rec);
        repeat (ROWS) begin  // Tile must stay quiet after run_done
            @(negedge clk);
            if (run_done || out_valid || busy)
                report_error($sformatf("%s: activity after run_done", test));
        end
    endtask

    // ========================================
    // Directed tests
    // ========================================
    task automatic idle_after_reset();
        int errs;
        errs = errors;
        repeat (2 * ROWS) begin
            @(negedge clk);
            if (busy || run_done || out_valid)
                report_error("reset_idle: tile active without run");
        end
        finish_test("reset_idle", errs);
    endtask

    task automatic handcrafted_subsets();
        int errs;
        errs = errors;
        for (int r = 0; r < ROWS; r++)
            write_entry(0, r, SPIKES'(HAND[r % 8]));
        end_writes();
        run_and_check("handcrafted", 1);
        finish_test("handcrafted", errs);
    endtask

    task automatic multi_timestep_order();
        int errs;
        errs = errors;
        for (int ts = 0; ts < MAX_TIMESTEPS; ts++)
            for (int r = 0; r < ROWS; r++)
                write_entry(ts, r, SPIKES'(((ts + 1) << 4) | r));  // Distinct per timestep
        end_writes();
        run_and_check("multi_timestep", MAX_TIMESTEPS);
        finish_test("multi_timestep", errs);
    endtask

    task automatic zero_and_identical();
        int errs;
        errs = errors;
        for (int r = 0; r < ROWS; r++) begin
            write_entry(0, r, '0);
            write_entry(1, r, SPIKES'(8'hA5));
        end
        end_writes();
        run_and_check("zero_identical", 2);
        finish_test("zero_identical", errs);
    endtask

    task automatic random_patterns();
        int                errs;
        logic [SPIKES-1:0] p;
        errs = errors;
        for (int a = 0; a < MAX_TIMESTEPS * ROWS; a++) begin
            draw_pattern(p);
            write_entry(a / ROWS, a % ROWS, p);
        end
        end_writes();
        run_and_check("random", MAX_TIMESTEPS);
        finish_test("random", errs);
    endtask

    task automatic back_to_back_runs();
        int                errs;
        logic [SPIKES-1:0] p;
        errs = errors;
        run_and_check("back_to_back", MAX_TIMESTEPS);
        for (int a = 0; a < 2 * ROWS; a++) begin  // New data for the first two timesteps
            draw_pattern(p);
            write_entry(a / ROWS, a % ROWS, p);
        end
        end_writes();
        run_and_check("back_to_back", 2);
        finish_test("back_to_back", errs);
    endtask

    // ========================================
    // Main sequence and watchdog
    // ========================================
    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        run           = 1'b0;
        num_timesteps = '0;
        host_wr_en    = 1'b0;
        host_wr_addr  = '0;
        host_wr_data  = '0;
        lfsr          = 16'd40579;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        idle_after_reset();
        handcrafted_subsets();
        multi_timestep_order();
        zero_and_identical();
        random_patterns();
        back_to_back_runs();
        if (UUT.u_props.fail_count != 0)
            report_error($sformatf("%0d protocol assertions failed during the run",
                                   UUT.u_props.fail_count));
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles, run never completed",
                 WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== prosperity_tile.f ====
hw/snn_tile_pkg.sv
hw/timestep_controller.sv
hw/spike_injector.sv
hw/subset_tcam.sv
hw/sparsity_detector.sv
hw/prosperity_tile.sv
testbench/prosperity_tile_props.sv
testbench/tb_prosperity_tile.sv

// ==== Bender.yml ====
package:
  name: prosperity_tile

sources:
  - files:
      - hw/snn_tile_pkg.sv
      - hw/timestep_controller.sv
      - hw/spike_injector.sv
      - hw/subset_tcam.sv
      - hw/sparsity_detector.sv
      - hw/prosperity_tile.sv
  - target: test
    files:
      - testbench/prosperity_tile_props.sv
      - testbench/tb_prosperity_tile.sv
